/* spi_pkg.sv */
package spi_pkg;

    // Widths
    localparam int WORD_WIDTH     = 8;
    localparam int APB_ADDR_WIDTH = 8;
    localparam int APB_DATA_WIDTH = 32;

    typedef logic [WORD_WIDTH-1:0]     spi_word_t;
    typedef logic [APB_ADDR_WIDTH-1:0] apb_addr_t;
    typedef logic [APB_DATA_WIDTH-1:0] apb_data_t;

    // Register map --------------------
    localparam apb_addr_t REG_CTRL   = 8'h00;
    localparam apb_addr_t REG_DIV    = 8'h04;
    localparam apb_addr_t REG_WAIT   = 8'h08;
    localparam apb_addr_t REG_TXDATA = 8'h0C;
    localparam apb_addr_t REG_RXDATA = 8'h10;
    localparam apb_addr_t REG_STATUS = 8'h14;

    // CTRL fields
    localparam int CTRL_CPOL     = 0;
    localparam int CTRL_CPHA     = 1;
    localparam int CTRL_ADDR_LSB = 2;

    // Reset values, also the smallest legal settings
    localparam int DIV_MIN  = 2;
    localparam int WAIT_MIN = 1;

    // STATUS bits --------------------
    localparam int STAT_TX_EMPTY = 0;
    localparam int STAT_TX_FULL  = 1;
    localparam int STAT_RX_EMPTY = 2;
    localparam int STAT_RX_FULL  = 3;

endpackage

/* axis_if.sv */
interface axis_if #(
    parameter int WIDTH = 8
);

    logic [WIDTH-1:0] tdata;
    logic             tlast;
    logic             tvalid;
    logic             tready;

    // Producer side of the stream
    modport source (output tdata, output tlast, output tvalid, input tready);

    // Consumer side of the stream
    modport sink (input tdata, input tlast, input tvalid, output tready);

endinterface

/* spi_if.sv */
interface spi_if #(
    parameter int SLAVE_NUM = 1
);

    logic                 sclk;
    logic                 mosi;
    logic                 miso;
    // One active-low select per slave
    logic [SLAVE_NUM-1:0] cs;

    modport master (output sclk, output mosi, output cs, input miso);

endinterface

/* spi_apb_regs.sv */
module spi_apb_regs #(
    parameter int  DATA_WIDTH = 8,
    parameter int  DIV_WIDTH  = 16,
    parameter int  WAIT_WIDTH = 16,
    parameter int  SLAVE_NUM  = 4,
    localparam int ADDR_WIDTH = (SLAVE_NUM > 1) ? $clog2(SLAVE_NUM) : 1
) (
    input  logic                    clk_i,
    input  logic                    rstn_i,
    input  logic                    psel_i,
    input  logic                    penable_i,
    input  logic                    pwrite_i,
    input  spi_pkg::apb_addr_t      paddr_i,
    input  spi_pkg::apb_data_t      pwdata_i,
    output spi_pkg::apb_data_t      prdata_o,
    output logic                    pready_o,
    output logic                    pslverr_o,
    axis_if.source                  tx_o,
    axis_if.sink                    rx_i,
    input  logic                    tx_empty_i,
    input  logic                    tx_full_i,
    input  logic                    rx_empty_i,
    input  logic                    rx_full_i,
    output logic                    cpol_o,
    output logic                    cpha_o,
    output logic [ADDR_WIDTH-1:0]   slave_addr_o,
    output logic [DIV_WIDTH-1:0]    clk_div_o,
    output logic [WAIT_WIDTH-1:0]   wait_time_o
);

    import spi_pkg::*;

    logic wr_en;
    logic rd_en;

    // Access phase of an APB transfer
    assign wr_en = psel_i & penable_i & pwrite_i;
    assign rd_en = psel_i & penable_i & ~pwrite_i;

    // No wait states
    assign pready_o = 1'b1;

    // Configuration registers --------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cpol_o       <= 1'b0;
            cpha_o       <= 1'b0;
            slave_addr_o <= '0;
            clk_div_o    <= DIV_WIDTH'(DIV_MIN);
            wait_time_o  <= WAIT_WIDTH'(WAIT_MIN);
        end else if (wr_en) begin
            case (paddr_i)
                REG_CTRL: begin
                    cpol_o       <= pwdata_i[CTRL_CPOL];
                    cpha_o       <= pwdata_i[CTRL_CPHA];
                    slave_addr_o <= pwdata_i[CTRL_ADDR_LSB +: ADDR_WIDTH];
                end
                REG_DIV: begin
                    clk_div_o <= pwdata_i[DIV_WIDTH-1:0];
                end
                REG_WAIT: begin
                    wait_time_o <= pwdata_i[WAIT_WIDTH-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // TX push and RX pop --------------------
    // Data in the low bits, last flag just above them
    assign tx_o.tdata  = pwdata_i[DATA_WIDTH-1:0];
    assign tx_o.tlast  = pwdata_i[DATA_WIDTH];
    assign tx_o.tvalid = wr_en && (paddr_i == REG_TXDATA);

    assign rx_i.tready = rd_en && (paddr_i == REG_RXDATA);

    // Read mux
    always_comb begin
        prdata_o = '0;
        case (paddr_i)
            REG_CTRL: begin
                prdata_o[CTRL_CPOL]                  = cpol_o;
                prdata_o[CTRL_CPHA]                  = cpha_o;
                prdata_o[CTRL_ADDR_LSB +: ADDR_WIDTH] = slave_addr_o;
            end
            REG_DIV: begin
                prdata_o[DIV_WIDTH-1:0] = clk_div_o;
            end
            REG_WAIT: begin
                prdata_o[WAIT_WIDTH-1:0] = wait_time_o;
            end
            REG_RXDATA: begin
                // Zero when nothing is queued
                if (rx_i.tvalid) begin
                    prdata_o[DATA_WIDTH-1:0] = rx_i.tdata;
                    prdata_o[DATA_WIDTH]     = rx_i.tlast;
                end
            end
            REG_STATUS: begin
                prdata_o[STAT_TX_EMPTY] = tx_empty_i;
                prdata_o[STAT_TX_FULL]  = tx_full_i;
                prdata_o[STAT_RX_EMPTY] = rx_empty_i;
                prdata_o[STAT_RX_FULL]  = rx_full_i;
            end
            default: begin
            end
        endcase
    end

    // Push into a full TX queue or pop from an empty RX queue
    assign pslverr_o = (wr_en && (paddr_i == REG_TXDATA) && tx_full_i) ||
                       (rd_en && (paddr_i == REG_RXDATA) && rx_empty_i);

endmodule

/* spi_stream_fifo.sv */
module spi_stream_fifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 8
) (
    input  logic   clk_i,
    input  logic   rstn_i,
    axis_if.sink   in_i,
    axis_if.source out_o,
    output logic   full_o,
    output logic   empty_o
);

    localparam int AW = $clog2(DEPTH);

    // Last flag stored above the data bits
    logic [WIDTH:0] mem [DEPTH];

    // Extra MSB on each pointer tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic [AW:0] wr_ptr_nxt;
    logic [AW:0] rd_ptr_nxt;
    logic        push;
    logic        pop;

    assign push = in_i.tvalid & ~full_o;
    assign pop  = out_o.tready & ~empty_o;

    assign wr_ptr_nxt = push ? wr_ptr + 1'b1 : wr_ptr;
    assign rd_ptr_nxt = pop ? rd_ptr + 1'b1 : rd_ptr;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            full_o  <= 1'b0;
            empty_o <= 1'b1;
        end else begin
            wr_ptr  <= wr_ptr_nxt;
            rd_ptr  <= rd_ptr_nxt;
            full_o  <= (wr_ptr_nxt[AW-1:0] == rd_ptr_nxt[AW-1:0]) &&
                       (wr_ptr_nxt[AW] != rd_ptr_nxt[AW]);
            empty_o <= (wr_ptr_nxt == rd_ptr_nxt);
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr[AW-1:0]] <= {in_i.tlast, in_i.tdata};
        end
    end

    assign in_i.tready  = ~full_o;
    assign out_o.tvalid = ~empty_o;
    assign out_o.tdata  = mem[rd_ptr[AW-1:0]][WIDTH-1:0];
    assign out_o.tlast  = mem[rd_ptr[AW-1:0]][WIDTH];

endmodule

/* axis_spi_master.sv */
module axis_spi_master #(
    parameter int  DATA_WIDTH = 8,
    parameter int  DIV_WIDTH  = 16,
    parameter int  WAIT_WIDTH = 16,
    parameter int  SLAVE_NUM  = 4,
    localparam int ADDR_WIDTH = (SLAVE_NUM > 1) ? $clog2(SLAVE_NUM) : 1
) (
    input  logic                  clk_i,
    input  logic                  rstn_i,
    input  logic                  cpol_i,
    input  logic                  cpha_i,
    input  logic [ADDR_WIDTH-1:0] addr_i,
    input  logic [DIV_WIDTH-1:0]  clk_divider_i,
    input  logic [WAIT_WIDTH-1:0] wait_time_i,
    spi_if.master                 m_spi,
    axis_if.sink                  s_axis,
    axis_if.source                m_axis
);

    localparam int BIT_CNT_W = (DATA_WIDTH > 1) ? $clog2(DATA_WIDTH) : 1;
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(DATA_WIDTH - 1);

    typedef enum logic [1:0] {
        IDLE,
        DATA,
        WAIT
    } state_e;

    state_e state;

    logic [DIV_WIDTH-1:0]  clk_cnt;
    logic [DIV_WIDTH-1:0]  half_limit;
    logic [DIV_WIDTH-1:0]  full_limit;
    logic                  half_tick;
    logic                  full_tick;
    logic                  last_tick;
    logic                  sample_tick;
    logic                  shift_tick;
    logic [BIT_CNT_W-1:0]  bit_cnt;

    logic [WAIT_WIDTH-1:0] wait_cnt;
    logic [WAIT_WIDTH-1:0] wait_cnt_nxt;
    logic                  wait_done;

    logic                  cs_q;
    logic [ADDR_WIDTH-1:0] addr_q;
    logic                  tlast_flag;
    logic [DATA_WIDTH-1:0] tx_shift;
    logic [DATA_WIDTH-1:0] rx_shift;
    logic [1:0]            done_pipe;

    logic                  s_hs;
    logic                  m_hs;

    // Stream handshakes --------------------
    // No new transfer while a received byte is still on its way out
    assign s_axis.tready = (state == IDLE) && !m_axis.tvalid && (done_pipe == 2'b00);
    assign s_hs          = s_axis.tvalid & s_axis.tready;
    assign m_hs          = m_axis.tvalid & m_axis.tready;

    // Control FSM --------------------
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state      <= IDLE;
            cs_q       <= 1'b1;
            addr_q     <= '0;
            tlast_flag <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (s_hs) begin
                        state      <= DATA;
                        cs_q       <= 1'b0;
                        addr_q     <= addr_i;
                        tlast_flag <= s_axis.tlast;
                    end
                end
                DATA: begin
                    if (last_tick) begin
                        if (tlast_flag) begin
                            state <= WAIT;
                            cs_q  <= 1'b1;
                        end else begin
                            // Burst continues, cs stays low
                            state <= IDLE;
                        end
                    end
                end
                WAIT: begin
                    if (wait_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Chip select after a last byte
    assign wait_cnt_nxt = wait_cnt + 1'b1;
    assign wait_done    = (wait_cnt_nxt >= wait_time_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i || state != WAIT) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt_nxt;
        end
    end

    // Select only the addressed slave
    always_comb begin
        for (int i = 0; i < SLAVE_NUM; i++) begin
            m_spi.cs[i] = (addr_q == ADDR_WIDTH'(i)) ? cs_q : 1'b1;
        end
    end

    // Serial clock timing --------------------
    // Leading edge at half the divider, trailing edge at the full count
    assign half_limit = (clk_divider_i >> 1) - 1'b1;
    assign full_limit = clk_divider_i - 1'b1;
    assign half_tick  = (state == DATA) && (clk_cnt == half_limit);
    assign full_tick  = (state == DATA) && (clk_cnt == full_limit);
    assign last_tick  = full_tick && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk_i) begin
        if (!rstn_i || state != DATA) begin
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (full_tick) begin
            clk_cnt <= '0;
            bit_cnt <= bit_cnt + 1'b1;
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            m_spi.sclk <= cpol_i;
        end else if (state != DATA) begin
            // Idle level follows CPOL
            m_spi.sclk <= cpol_i;
        end else if (half_tick || full_tick) begin
            m_spi.sclk <= ~m_spi.sclk;
        end
    end

    // Data shifting --------------------
    // CPHA 0 samples on the leading edge and shifts on the trailing one
    assign sample_tick = cpha_i ? full_tick : half_tick;
    assign shift_tick  = cpha_i ? half_tick : (full_tick & ~last_tick);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            m_spi.mosi <= 1'b0;
        end else if (s_hs) begin
            // CPHA 0 needs the MSB on the line before the first edge
            if (!cpha_i) begin
                m_spi.mosi <= s_axis.tdata[DATA_WIDTH-1];
            end
        end else if (shift_tick) begin
            m_spi.mosi <= tx_shift[DATA_WIDTH-1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_hs) begin
            tx_shift <= cpha_i ? s_axis.tdata : (s_axis.tdata << 1);
        end else if (shift_tick) begin
            tx_shift <= tx_shift << 1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sample_tick) begin
            rx_shift <= {rx_shift[DATA_WIDTH-2:0], m_spi.miso};
        end
    end

    // Received byte --------------------
    // Two cycles from the final sclk edge to tvalid
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            done_pipe     <= 2'b00;
            m_axis.tvalid <= 1'b0;
        end else begin
            done_pipe <= {done_pipe[0], last_tick};
            if (done_pipe[1]) begin
                m_axis.tvalid <= 1'b1;
            end else if (m_hs) begin
                m_axis.tvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (done_pipe[1]) begin
            m_axis.tdata <= rx_shift;
            m_axis.tlast <= tlast_flag;
        end
    end

endmodule

/* spi_apb_top.sv */
module spi_apb_top #(
    parameter int DATA_WIDTH = spi_pkg::WORD_WIDTH,
    parameter int DIV_WIDTH  = 16,
    parameter int WAIT_WIDTH = 16,
    parameter int SLAVE_NUM  = 4,
    parameter int FIFO_DEPTH = 16
) (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 psel_i,
    input  logic                 penable_i,
    input  logic                 pwrite_i,
    input  spi_pkg::apb_addr_t   paddr_i,
    input  spi_pkg::apb_data_t   pwdata_i,
    output spi_pkg::apb_data_t   prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o,
    output logic                 spi_sclk_o,
    output logic                 spi_mosi_o,
    output logic [SLAVE_NUM-1:0] spi_cs_o,
    input  logic                 spi_miso_i
);

    localparam int ADDR_WIDTH = (SLAVE_NUM > 1) ? $clog2(SLAVE_NUM) : 1;

    logic                  cpol;
    logic                  cpha;
    logic [ADDR_WIDTH-1:0] slave_addr;
    logic [DIV_WIDTH-1:0]  clk_div;
    logic [WAIT_WIDTH-1:0] wait_time;
    logic                  tx_full;
    logic                  tx_empty;
    logic                  rx_full;
    logic                  rx_empty;

    axis_if #(.WIDTH(DATA_WIDTH)) tx_push ();
    axis_if #(.WIDTH(DATA_WIDTH)) tx_pop ();
    axis_if #(.WIDTH(DATA_WIDTH)) rx_push ();
    axis_if #(.WIDTH(DATA_WIDTH)) rx_pop ();
    spi_if #(.SLAVE_NUM(SLAVE_NUM)) spi_bus ();

    // Host registers
    spi_apb_regs #(
        .DATA_WIDTH(DATA_WIDTH),
        .DIV_WIDTH (DIV_WIDTH),
        .WAIT_WIDTH(WAIT_WIDTH),
        .SLAVE_NUM (SLAVE_NUM)
    ) regs_inst (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .paddr_i     (paddr_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .tx_o        (tx_push),
        .rx_i        (rx_pop),
        .tx_empty_i  (tx_empty),
        .tx_full_i   (tx_full),
        .rx_empty_i  (rx_empty),
        .rx_full_i   (rx_full),
        .cpol_o      (cpol),
        .cpha_o      (cpha),
        .slave_addr_o(slave_addr),
        .clk_div_o   (clk_div),
        .wait_time_o (wait_time)
    );

    spi_stream_fifo #(
        .DEPTH(FIFO_DEPTH),
        .WIDTH(DATA_WIDTH)
    ) tx_fifo_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .in_i   (tx_push),
        .out_o  (tx_pop),
        .full_o (tx_full),
        .empty_o(tx_empty)
    );

    axis_spi_master #(
        .DATA_WIDTH(DATA_WIDTH),
        .DIV_WIDTH (DIV_WIDTH),
        .WAIT_WIDTH(WAIT_WIDTH),
        .SLAVE_NUM (SLAVE_NUM)
    ) engine_inst (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .cpol_i       (cpol),
        .cpha_i       (cpha),
        .addr_i       (slave_addr),
        .clk_divider_i(clk_div),
        .wait_time_i  (wait_time),
        .m_spi        (spi_bus),
        .s_axis       (tx_pop),
        .m_axis       (rx_push)
    );

    spi_stream_fifo #(
        .DEPTH(FIFO_DEPTH),
        .WIDTH(DATA_WIDTH)
    ) rx_fifo_inst (
        .clk_i  (clk_i),
        .rstn_i (rstn_i),
        .in_i   (rx_push),
        .out_o  (rx_pop),
        .full_o (rx_full),
        .empty_o(rx_empty)
    );

    // SPI pins
    assign spi_sclk_o   = spi_bus.sclk;
    assign spi_mosi_o   = spi_bus.mosi;
    assign spi_cs_o     = spi_bus.cs;
    assign spi_bus.miso = spi_miso_i;

endmodule

/* spi_slave_model.sv */
module spi_slave_model #(
    parameter int SLAVE_NUM = 4
) (
    input  logic                 spi_sclk_i,
    input  logic                 spi_mosi_i,
    input  logic [SLAVE_NUM-1:0] spi_cs_i,
    output logic                 spi_miso_o,
    input  logic                 cpol_i,
    input  logic                 cpha_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [7:0] reply;
    logic [7:0] rx_sr;
    logic [7:0] rx_log [$];
    int         bit_cnt;
    logic       prev_sclk;
    logic       prev_active;
    logic       active;
    logic       leading;
    realtime    cs_rise_time;

    initial begin
        reply        = 8'hA5;
        rx_sr        = 8'h00;
        bit_cnt      = 0;
        spi_miso_o   = 1'b0;
        prev_sclk    = 1'b0;
        prev_active  = 1'b0;
        cs_rise_time = -1.0;
    end

    always @(spi_sclk_i or spi_cs_i) begin
        active = (spi_cs_i != '1);
        // The final sclk edge can land in the same step as cs rising
        if (!active && prev_active) begin
            cs_rise_time = $realtime;
        end
        if (active && !prev_active) begin
            bit_cnt    = 0;
            spi_miso_o = reply[7];
        end
        if ((spi_sclk_i != prev_sclk) && (active || cs_rise_time == $realtime)) begin
            leading = (spi_sclk_i != cpol_i);
            if (leading == !cpha_i) begin
                rx_sr   = {rx_sr[6:0], spi_mosi_i};
                bit_cnt = bit_cnt + 1;
                if (bit_cnt == 8) begin
                    rx_log.push_back(rx_sr);
                    // Next answer is the complement of this byte
                    reply   = ~rx_sr;
                    bit_cnt = 0;
                end
            end else begin
                spi_miso_o = reply[7-bit_cnt];
            end
        end
        prev_sclk   = spi_sclk_i;
        prev_active = active;
    end

endmodule

/* spi_apb_tb.sv */
module spi_apb_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import spi_pkg::*;

    localparam int SLAVE_NUM   = 4;
    localparam int FIFO_DEPTH  = 16;
    localparam int CYCLE_LIMIT = 40000;

    logic                 clk_i;
    logic                 rstn_i;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    apb_addr_t            paddr;
    apb_data_t            pwdata;
    apb_data_t            prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 spi_sclk;
    logic                 spi_mosi;
    logic                 spi_miso;
    logic [SLAVE_NUM-1:0] spi_cs;

    // Configuration as last written by the host
    logic       cfg_cpol;
    logic       cfg_cpha;
    logic [1:0] cfg_addr;
    int         cfg_wait;
    int         ctrl_cycle;

    int         cycle;
    int         mismatch_count;
    int         failure_count;
    int         monitor_fail_count;
    int         bus_fail_count;
    int         seed;
    int         cs_rises;
    int         cs_high_cnt;
    logic       cs_prev_high;
    int         cs_low_cycles [SLAVE_NUM];

    // Reference model of the slave's answers
    logic       have_prev;
    logic [7:0] prev_sent;
    logic [8:0] exp_q [$];
    logic [7:0] sent_q [$];

    spi_apb_top spi_apb_top_inst (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .spi_sclk_o(spi_sclk),
        .spi_mosi_o(spi_mosi),
        .spi_cs_o  (spi_cs),
        .spi_miso_i(spi_miso)
    );

    spi_slave_model #(.SLAVE_NUM(SLAVE_NUM)) slave_inst (
        .spi_sclk_i(spi_sclk),
        .spi_mosi_i(spi_mosi),
        .spi_cs_i  (spi_cs),
        .spi_miso_o(spi_miso),
        .cpol_i    (cfg_cpol),
        .cpha_i    (cfg_cpha)
    );

    initial begin
        clk_i = 1'b0;
    end

    always #5 clk_i = ~clk_i;

    assert property (@(posedge clk_i) disable iff (!rstn_i) pready)
    else begin
        bus_fail_count++;
        $display("Error: pready was low during an APB access");
    end

    // Bus monitor --------------------
    always @(posedge clk_i) begin
        cycle = cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks done: %0d mismatches, %0d other errors", mismatch_count,
                     failure_count + monitor_fail_count + bus_fail_count + 1);
            $display("Testbench failed");
            $finish;
        end else if (rstn_i) begin
            if (&spi_cs) begin
                if (!cs_prev_high) begin
                    cs_rises = cs_rises + 1;
                end
                cs_high_cnt = cs_high_cnt + 1;
                // Idle level of sclk once a CTRL change has settled
                if (cycle - ctrl_cycle > 3) begin
                    assert (spi_sclk == cfg_cpol)
                    else begin
                        monitor_fail_count++;
                        $display("Error: sclk not at its idle level while cs is high");
                    end
                end
            end else begin
                if (cs_prev_high) begin
                    assert (cs_high_cnt >= cfg_wait)
                    else begin
                        monitor_fail_count++;
                        $display("Error: cs high for %0d cycles, below WAIT %0d",
                                 cs_high_cnt, cfg_wait);
                    end
                end
                assert (spi_cs == ~(4'b0001 << cfg_addr))
                else begin
                    monitor_fail_count++;
                    $display("Error: cs pattern %b does not select slave %0d",
                             spi_cs, cfg_addr);
                end
                cs_high_cnt = 0;
                for (int i = 0; i < SLAVE_NUM; i++) begin
                    if (!spi_cs[i]) begin
                        cs_low_cycles[i] = cs_low_cycles[i] + 1;
                    end
                end
            end
            cs_prev_high = &spi_cs;
        end
    end

    // Checks and APB tasks --------------------
    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp == act)
        else begin
            mismatch_count++;
            $display("Mismatch in %s: expected 0x%0h, actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic check_true(input string what, input logic cond);
        assert (cond)
        else begin
            failure_count++;
            $display("Error: %s", what);
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data,
                             output logic err);
        @(posedge clk_i);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk_i);
        #1;
        penable = 1'b1;
        @(negedge clk_i);
        err = pslverr;
        @(posedge clk_i);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data,
                            output logic err);
        @(posedge clk_i);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk_i);
        #1;
        penable = 1'b1;
        @(negedge clk_i);
        data = prdata;
        err  = pslverr;
        @(posedge clk_i);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic set_ctrl(input logic cpol, input logic cpha, input logic [1:0] addr);
        logic err;
        apb_write(REG_CTRL, {28'b0, addr, cpha, cpol}, err);
        cfg_cpol   = cpol;
        cfg_cpha   = cpha;
        cfg_addr   = addr;
        ctrl_cycle = cycle;
    endtask

    task automatic send_byte(input logic [7:0] data, input logic last, output logic err);
        apb_write(REG_TXDATA, {23'b0, last, data}, err);
        if (!err) begin
            exp_q.push_back({last, have_prev ? ~prev_sent : 8'hA5});
            sent_q.push_back(data);
            prev_sent = data;
            have_prev = 1'b1;
        end
    endtask

    task automatic receive_byte(input string name, output logic last);
        apb_data_t  d;
        logic       err;
        logic [8:0] exp;
        logic [7:0] sent;
        apb_read(REG_STATUS, d, err);
        while (d[STAT_RX_EMPTY]) begin
            apb_read(REG_STATUS, d, err);
        end
        apb_read(REG_RXDATA, d, err);
        check_true({name, ": pslverr on a non-empty RXDATA read"}, !err);
        exp  = exp_q.pop_front();
        sent = sent_q.pop_front();
        check_value({name, " rx item"}, 32'(exp), 32'(d[8:0]));
        check_true({name, ": slave recorded no byte"}, slave_inst.rx_log.size() > 0);
        if (slave_inst.rx_log.size() > 0) begin
            check_value({name, " mosi"}, 32'(sent), 32'(slave_inst.rx_log.pop_front()));
        end
        last = d[8];
    endtask

    // Tests --------------------
    initial begin
        apb_data_t d;
        logic      err;
        logic      last;
        logic      sclk_start;
        int        base;
        int        low_base [SLAVE_NUM];

        rstn_i = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        cfg_cpol = 1'b0;
        cfg_cpha = 1'b0;
        cfg_addr = 2'd0;
        cfg_wait = 1;
        ctrl_cycle = 0;
        cycle = 0;
        mismatch_count = 0;
        failure_count = 0;
        monitor_fail_count = 0;
        bus_fail_count = 0;
        seed = 32'h44c6_f1b2;
        cs_rises = 0;
        cs_high_cnt = 0;
        cs_prev_high = 1'b1;
        for (int i = 0; i < SLAVE_NUM; i++) begin
            cs_low_cycles[i] = 0;
        end
        have_prev = 1'b0;
        prev_sent = 8'h00;

        repeat (16) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        check_value("reset cs", 32'hF, 32'(spi_cs));
        check_value("reset sclk", 32'h0, 32'(spi_sclk));
        check_value("reset mosi", 32'h0, 32'(spi_mosi));
        check_value("reset pslverr", 32'h0, 32'(pslverr));

        // Register readback
        set_ctrl(1'b1, 1'b1, 2'd2);
        apb_read(REG_CTRL, d, err);
        check_value("ctrl readback", 32'h0B, d);
        apb_write(REG_DIV, 32'd8, err);
        apb_read(REG_DIV, d, err);
        check_value("div readback", 32'd8, d);
        apb_write(REG_WAIT, 32'd20, err);
        cfg_wait = 20;
        apb_read(REG_WAIT, d, err);
        check_value("wait readback", 32'd20, d);

        // Empty RX read
        apb_read(REG_RXDATA, d, err);
        check_value("empty rx data", 32'h0, d);
        check_value("empty rx pslverr", 32'h1, 32'(err));

        // All four SPI modes
        for (int m = 0; m < 4; m++) begin
            set_ctrl(m[0], m[1], 2'd0);
            send_byte(8'($random(seed)), 1'b1, err);
            receive_byte($sformatf("mode %0d", m), last);
        end

        // Burst of five with the last flag on the final byte only
        set_ctrl(1'b0, 1'b0, 2'd0);
        base = cs_rises;
        for (int i = 0; i < 5; i++) begin
            send_byte(8'($random(seed)), (i == 4), err);
        end
        for (int i = 0; i < 5; i++) begin
            receive_byte("burst", last);
            check_value("burst last", 32'(i == 4), 32'(last));
        end
        check_value("burst cs rises", 32'd1, 32'(cs_rises - base));

        // Slave select decode
        for (int k = 0; k < SLAVE_NUM; k++) begin
            set_ctrl(1'b0, 1'b0, 2'(k));
            for (int j = 0; j < SLAVE_NUM; j++) begin
                low_base[j] = cs_low_cycles[j];
            end
            send_byte(8'($random(seed)), 1'b1, err);
            receive_byte("slave select", last);
            for (int j = 0; j < SLAVE_NUM; j++) begin
                check_value($sformatf("cs%0d low for slave %0d", j, k), 32'(j == k),
                            32'(cs_low_cycles[j] != low_base[j]));
            end
        end

        // TX FIFO overflow with a slow serial clock
        set_ctrl(1'b0, 1'b0, 2'd0);
        apb_write(REG_DIV, 32'd40, err);
        for (int i = 0; i < 20; i++) begin
            send_byte(8'($random(seed)), 1'b1, err);
            check_value($sformatf("tx write %0d pslverr", i + 1),
                        32'(i > FIFO_DEPTH), 32'(err));
        end
        apb_read(REG_STATUS, d, err);
        check_value("tx full status", 32'h1, 32'(d[STAT_TX_FULL]));
        for (int i = 0; i < FIFO_DEPTH + 1; i++) begin
            receive_byte("tx overflow", last);
        end

        // RX FIFO full stalls the engine
        apb_write(REG_DIV, 32'd8, err);
        for (int i = 0; i < 18; i++) begin
            apb_read(REG_STATUS, d, err);
            while (d[STAT_TX_FULL]) begin
                apb_read(REG_STATUS, d, err);
            end
            send_byte(8'($random(seed)), 1'b1, err);
            check_value("rx full write pslverr", 32'h0, 32'(err));
        end
        apb_read(REG_STATUS, d, err);
        while (!d[STAT_RX_FULL]) begin
            apb_read(REG_STATUS, d, err);
        end
        // The engine serializes one more byte and then holds it
        while (slave_inst.rx_log.size() < FIFO_DEPTH + 1) begin
            @(negedge clk_i);
        end
        while (!(&spi_cs)) begin
            @(negedge clk_i);
        end
        sclk_start = spi_sclk;
        repeat (100) begin
            @(negedge clk_i);
            check_true("sclk toggled while the RX FIFO was full", spi_sclk == sclk_start);
        end
        for (int i = 0; i < 18; i++) begin
            receive_byte("rx full", last);
        end

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_count,
                 failure_count + monitor_fail_count + bus_fail_count);
        if (mismatch_count + failure_count + monitor_fail_count + bus_fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* compile.f */
spi_pkg.sv
axis_if.sv
spi_if.sv
spi_apb_regs.sv
spi_stream_fifo.sv
axis_spi_master.sv
spi_apb_top.sv
spi_slave_model.sv
spi_apb_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run with Verilator; exit status follows the testbench result
cd "$(dirname "$0")" &&
verilator --binary -f compile.f --top-module spi_apb_tb -o spi_apb_sim &&
./obj_dir/spi_apb_sim | tee /dev/stderr | grep -q "Testbench passed" &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
